//--- project.f
+incdir+.
noise_est_pkg.sv
frame_memory.sv
block_reader.sv
block_noise_stats.sv
noise_estimator_top.sv
tb_noise_estimator.sv

//--- run.sh
#!/bin/sh
# build the noise estimator testbench with Verilator and run it
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_noise_estimator \
	-f project.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "Result: FAILED" > sim.log; }
test -f sim.log || ./obj_dir/tb_sim > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

//--- tb_noise_estimator.sv
// noise estimator testbench: random frames from a fixed seed checked against a block variance model
`timescale 1ns/1ps
`include "noise_est_macros.svh"

module tb_noise_estimator;
	import noise_est_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int MEM_SIZE   = 1 << `NE_ADDR_W;
	localparam int BS         = `NE_BLOCK_SIZE;
	localparam int N_RAND     = 8;  // random-size frames
	localparam int N_FRAMES   = N_RAND + 3;
	// full frame, random frames up to 64x32, flat block frame, back-pressure frame
	localparam int TOTAL_PIX  = 4096 + N_RAND * 2048 + 32 * 32 + 16 * 16;
	// load plus burst read per pixel, with slack per frame
	localparam longint WATCHDOG_NS = longint'(TOTAL_PIX * 4 + N_FRAMES * 200) * CLK_PERIOD;

	logic                  clk;
	logic                  rst_n;
	logic                  mem_wr_en;
	logic [`NE_ADDR_W-1:0] mem_wr_addr;
	logic [`NE_PIX_W-1:0]  mem_wr_data;
	logic                  frame_start;
	logic [`NE_ADDR_W-1:0] base_addr;
	logic [`NE_DIM_W-1:0]  frame_width;
	logic [`NE_DIM_W-1:0]  frame_height;
	logic                  busy;
	noise_result_t         result;
	logic                  result_valid;
	logic                  result_ready;

	logic [`NE_PIX_W-1:0] model_mem [0:MEM_SIZE-1];  // mirror of the frame memory

	int err_count    = 0;
	int starts       = 0;
	int results_seen = 0;

	noise_estimator_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_wr_en    (mem_wr_en),
		.mem_wr_addr  (mem_wr_addr),
		.mem_wr_data  (mem_wr_data),
		.frame_start  (frame_start),
		.base_addr    (base_addr),
		.frame_width  (frame_width),
		.frame_height (frame_height),
		.busy         (busy),
		.result       (result),
		.result_valid (result_valid),
		.result_ready (result_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run stalled after %0d ns without finishing", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	// results actually handed downstream
	always @(posedge clk) begin
		if (rst_n && result_valid && result_ready)
			results_seen <= results_seen + 1;
	end

	task automatic compare_value(input string name, input longint got, input longint exp);
		assert (got == exp)
		else begin
			err_count++;
			$display("CHECK FAILED t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond)
		else begin
			err_count++;
			$display("ERROR t=%0t: %s", $time, what);
		end
	endtask

	// smallest 64*sum(x^2) - sum(x)^2 over all blocks of the frame
	function automatic longint min_block_metric(input int base, input int w, input int h);
		longint best;
		longint s;
		longint sq;
		longint m;
		longint p;
		best = 64'h7fff_ffff_ffff_ffff;
		for (int by = 0; by < h / BS; by++) begin
			for (int bx = 0; bx < w / BS; bx++) begin
				s  = 0;
				sq = 0;
				for (int r = 0; r < BS; r++) begin
					for (int c = 0; c < BS; c++) begin
						p  = longint'(model_mem[base + (by * BS + r) * w + bx * BS + c]);
						s  += p;
						sq += p * p;
					end
				end
				m = BS * BS * sq - s * s;
				if (m < best)
					best = m;
			end
		end
		return best;
	endfunction

	// random pixels, one block optionally held at a single value
	task automatic load_frame(input int base, input int w, input int h,
			input int flat_bx, input int flat_by);
		int                   addr;
		logic [`NE_PIX_W-1:0] flat_pix;
		logic [`NE_PIX_W-1:0] pix;
		flat_pix = `NE_PIX_W'($urandom);
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				addr = base + r * w + c;
				if (r / BS == flat_by && c / BS == flat_bx)
					pix = flat_pix;
				else
					pix = `NE_PIX_W'($urandom);
				model_mem[addr] = pix;
				@(posedge clk);
				mem_wr_en   <= 1'b1;
				mem_wr_addr <= `NE_ADDR_W'(addr);
				mem_wr_data <= pix;
			end
		end
		@(posedge clk);
		mem_wr_en <= 1'b0;
	endtask

	task automatic run_frame(input int base, input int w, input int h,
			input int flat_bx, input int flat_by, input int hold, input bit poke_start);
		noise_result_t held;
		longint        exp_metric;
		load_frame(base, w, h, flat_bx, flat_by);
		exp_metric = min_block_metric(base, w, h);
		@(posedge clk);
		frame_start  <= 1'b1;
		base_addr    <= `NE_ADDR_W'(base);
		frame_width  <= `NE_DIM_W'(w);
		frame_height <= `NE_DIM_W'(h);
		result_ready <= 1'b0;
		@(posedge clk);
		frame_start <= 1'b0;
		starts++;
		while (!result_valid)
			@(posedge clk);
		held = result;
		// back-pressure, maybe with a stray start that must be ignored
		for (int i = 0; i < hold; i++) begin
			frame_start <= poke_start && (i == 1);
			@(posedge clk);
			check_true(result_valid, "result_valid dropped while result_ready was low");
			check_true(busy, "busy fell while the result was held");
			compare_value("result (held)", longint'(result), longint'(held));
		end
		frame_start  <= 1'b0;
		result_ready <= 1'b1;
		@(posedge clk);  // handshake edge
		result_ready <= 1'b0;
		compare_value("result.metric", result.metric, exp_metric);
		compare_value("result.blocks", result.blocks, (w / BS) * (h / BS));
		compare_value("result.base", result.base, base);
		while (busy)
			@(posedge clk);
		repeat (4) begin
			@(posedge clk);
			check_true(!result_valid, "extra result appeared without an accepted start");
			check_true(!busy, "reader restarted from an ignored frame_start");
		end
		compare_value("result count", results_seen, starts);
	endtask

	initial begin
		int w;
		int h;
		int base;
		void'($urandom(32'h21e6463d));
		rst_n        = 1'b0;
		mem_wr_en    = 1'b0;
		mem_wr_addr  = '0;
		mem_wr_data  = '0;
		frame_start  = 1'b0;
		base_addr    = '0;
		frame_width  = '0;
		frame_height = '0;
		result_ready = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_true(!result_valid, "result_valid high after reset");
		check_true(!busy, "busy high after reset");

		// full 64x64 frame at base 0
		run_frame(0, 64, 64, -1, -1, $urandom_range(0, 5), 1'b0);

		repeat (N_RAND) begin
			w    = BS * $urandom_range(1, 8);
			h    = BS * $urandom_range(1, 4);
			base = BS * $urandom_range(0, (MEM_SIZE - w * h) / BS);
			run_frame(base, w, h, -1, -1, $urandom_range(0, 5), 1'b0);
		end

		// one constant block among noisy ones
		base = BS * $urandom_range(0, (MEM_SIZE - 32 * 32) / BS);
		run_frame(base, 32, 32, $urandom_range(0, 3), $urandom_range(0, 3),
			$urandom_range(0, 5), 1'b0);
		compare_value("flat block result.metric", result.metric, 0);

		// long hold with a start pulse in the middle
		base = BS * $urandom_range(0, (MEM_SIZE - 16 * 16) / BS);
		run_frame(base, 16, 16, -1, -1, 6 + $urandom_range(0, 4), 1'b1);

		$display("errors: %0d checks failed, %0d results for %0d starts",
			err_count, results_seen, starts);
		if (err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- noise_estimator_top.sv
// noise estimator top: frame memory, block reader and block statistics
`timescale 1ns/1ps
`include "noise_est_macros.svh"

module noise_estimator_top (
	input  logic                          clk,
	input  logic                          rst_n,
	// frame load port
	input  logic                          mem_wr_en,
	input  logic [`NE_ADDR_W-1:0]         mem_wr_addr,
	input  logic [`NE_PIX_W-1:0]          mem_wr_data,
	// frame control
	input  logic                          frame_start,
	input  logic [`NE_ADDR_W-1:0]         base_addr,
	input  logic [`NE_DIM_W-1:0]          frame_width,
	input  logic [`NE_DIM_W-1:0]          frame_height,
	output logic                          busy,
	// to the wiener stage
	output noise_est_pkg::noise_result_t  result,
	output logic                          result_valid,
	input  logic                          result_ready
);
	import noise_est_pkg::*;

	rd_req_t               req;
	logic                  req_valid;
	logic                  req_ready;
	rd_beat_t              beat;
	logic                  beat_valid;
	logic                  frame_end;
	logic [`NE_ADDR_W-1:0] base_out;
	logic                  stats_idle;

	frame_memory u_frame_memory (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (mem_wr_en),
		.wr_addr    (mem_wr_addr),
		.wr_data    (mem_wr_data),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.beat       (beat),
		.beat_valid (beat_valid)
	);

	block_reader u_block_reader (
		.clk          (clk),
		.rst_n        (rst_n),
		.frame_start  (frame_start),
		.base_addr    (base_addr),
		.frame_width  (frame_width),
		.frame_height (frame_height),
		.req_ready    (req_ready),
		.beat         (beat),
		.beat_valid   (beat_valid),
		.stats_idle   (stats_idle),
		.busy         (busy),
		.req          (req),
		.req_valid    (req_valid),
		.frame_end    (frame_end),
		.base_out     (base_out)
	);

	block_noise_stats u_block_noise_stats (
		.clk          (clk),
		.rst_n        (rst_n),
		.beat         (beat),
		.beat_valid   (beat_valid),
		.frame_end    (frame_end),
		.base_out     (base_out),
		.result_ready (result_ready),
		.stats_idle   (stats_idle),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

//--- block_noise_stats.sv
// block statistics: per-block variance metric, frame minimum and held result
`timescale 1ns/1ps
`include "noise_est_macros.svh"

module block_noise_stats (
	input  logic                          clk,
	input  logic                          rst_n,
	input  noise_est_pkg::rd_beat_t       beat,
	input  logic                          beat_valid,
	input  logic                          frame_end,
	input  logic [`NE_ADDR_W-1:0]         base_out,
	input  logic                          result_ready,
	output logic                          stats_idle,
	output noise_est_pkg::noise_result_t  result,
	output logic                          result_valid
);
	import noise_est_pkg::*;

	localparam int BLK_SH = 2 * $clog2(`NE_BLOCK_SIZE);  // log2 of pixels per block
	localparam int SUM_W  = `NE_PIX_W + BLK_SH;
	localparam int SQ_W   = 2 * `NE_PIX_W + BLK_SH;

	logic [BLK_SH-1:0]       pix_cnt;
	logic [SUM_W-1:0]        sum_q;
	logic [SUM_W-1:0]        sum_nx;
	logic [SQ_W-1:0]         sq_q;
	logic [SQ_W-1:0]         sq_nx;
	logic [SQ_W-1:0]         pix_sq;
	logic [`NE_METRIC_W-1:0] sum_w;
	logic [`NE_METRIC_W-1:0] sq_w;
	logic [`NE_METRIC_W-1:0] metric_nx;
	logic [`NE_METRIC_W-1:0] metric_q;
	logic [`NE_METRIC_W-1:0] min_q;
	logic                    metric_valid;
	logic                    block_close;
	logic                    fold_q;
	blk_count_t              blk_count;
	logic [`NE_ADDR_W-1:0]   frame_base;

	assign block_close = beat_valid && (pix_cnt == '1);

	// sums including the current beat
	always_comb begin
		pix_sq    = SQ_W'(beat.pix) * SQ_W'(beat.pix);
		sum_nx    = sum_q + SUM_W'(beat.pix);
		sq_nx     = sq_q + pix_sq;
		sum_w     = `NE_METRIC_W'(sum_nx);
		sq_w      = `NE_METRIC_W'(sq_nx);
		metric_nx = (sq_w << BLK_SH) - sum_w * sum_w;  // 64*sum(x^2) - sum(x)^2
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_cnt      <= '0;
			sum_q        <= '0;
			sq_q         <= '0;
			metric_valid <= 1'b0;
		end else begin
			metric_valid <= block_close;
			if (beat_valid) begin
				pix_cnt <= pix_cnt + 1'b1;  // every 64 beats form one block
				if (block_close) begin
					sum_q <= '0;
					sq_q  <= '0;
				end else begin
					sum_q <= sum_nx;
					sq_q  <= sq_nx;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (block_close)
			metric_q <= metric_nx;
	end

	// frame minimum and result handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			min_q        <= '1;
			blk_count    <= '0;
			fold_q       <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			fold_q <= frame_end;
			if (fold_q) begin
				min_q     <= '1;  // ready for the next frame
				blk_count <= '0;
			end else if (metric_valid) begin
				blk_count <= blk_count + 1'b1;
				if (metric_q < min_q)
					min_q <= metric_q;
			end
			if (fold_q)
				result_valid <= 1'b1;
			else if (result_ready)
				result_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (frame_end)
			frame_base <= base_out;
		if (fold_q)
			result <= '{base: frame_base, metric: min_q, blocks: blk_count};
	end

	// busy from frame_end until the result leaves
	assign stats_idle = !(frame_end || fold_q || result_valid);

	a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid && !result_ready |=> result_valid && $stable(result))
		else $error("result dropped or changed under back-pressure");

endmodule

//--- block_reader.sv
// block reader: walks the frame in 8x8 blocks and issues one burst per block row
`timescale 1ns/1ps
`include "noise_est_macros.svh"

module block_reader (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     frame_start,
	input  logic [`NE_ADDR_W-1:0]    base_addr,
	input  logic [`NE_DIM_W-1:0]     frame_width,
	input  logic [`NE_DIM_W-1:0]     frame_height,
	input  logic                     req_ready,
	input  noise_est_pkg::rd_beat_t  beat,
	input  logic                     beat_valid,
	input  logic                     stats_idle,
	output logic                     busy,
	output noise_est_pkg::rd_req_t   req,
	output logic                     req_valid,
	output logic                     frame_end,
	output logic [`NE_ADDR_W-1:0]    base_out
);
	import noise_est_pkg::*;

	localparam int ROW_W = $clog2(`NE_BLOCK_SIZE);
	localparam int BLK_W = `NE_DIM_W - ROW_W;

	reader_state_t state, next_state;

	logic [ROW_W-1:0]      row_in_block;
	logic [BLK_W-1:0]      block_col;
	logic [BLK_W-1:0]      block_row;
	logic [`NE_DIM_W-1:0]  width_q;
	logic [`NE_DIM_W-1:0]  height_q;
	logic [BLK_W-1:0]      last_col_idx;
	logic [BLK_W-1:0]      last_row_idx;
	logic [`NE_ADDR_W-1:0] line_off;
	logic [`NE_ADDR_W-1:0] col_off;
	logic                  start_ok;
	logic                  burst_done;
	logic                  block_done;
	logic                  at_last_col;
	logic                  at_last_row;
	logic                  frame_done;

	assign start_ok     = (state == IDLE) && frame_start;
	assign last_col_idx = width_q[`NE_DIM_W-1:ROW_W] - 1'b1;
	assign last_row_idx = height_q[`NE_DIM_W-1:ROW_W] - 1'b1;

	assign burst_done  = (state == READ) && beat_valid && beat.last;
	assign block_done  = (row_in_block == '1);  // 8th row of the block
	assign at_last_col = (block_col == last_col_idx);
	assign at_last_row = (block_row == last_row_idx);
	assign frame_done  = burst_done && block_done && at_last_col && at_last_row;

	// pixel row = block_row*8 + row_in_block, then block column offset
	assign line_off = `NE_ADDR_W'({block_row, row_in_block}) * `NE_ADDR_W'(width_q);
	assign col_off  = `NE_ADDR_W'({block_col, {ROW_W{1'b0}}});

	assign req.addr  = base_out + line_off + col_off;
	assign req.len   = beat_cnt_t'(`NE_BLOCK_SIZE);
	assign req_valid = (state == REQUEST);
	assign busy      = (state != IDLE);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (frame_start)
					next_state = REQUEST;
			end
			REQUEST: begin
				if (req_ready)
					next_state = READ;
			end
			READ: begin
				if (frame_done)
					next_state = FRAME_DONE;
				else if (burst_done)
					next_state = REQUEST;
			end
			FRAME_DONE: begin
				if (stats_idle)  // hold off until the result is taken
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			row_in_block <= '0;
			block_col    <= '0;
			block_row    <= '0;
			frame_end    <= 1'b0;
		end else begin
			state     <= next_state;
			frame_end <= frame_done;  // one cycle after the last beat
			if (start_ok) begin
				row_in_block <= '0;
				block_col    <= '0;
				block_row    <= '0;
			end else if (burst_done) begin
				row_in_block <= row_in_block + 1'b1;  // wraps at the block edge
				if (block_done) begin
					if (at_last_col) begin
						block_col <= '0;
						block_row <= block_row + 1'b1;
					end else begin
						block_col <= block_col + 1'b1;
					end
				end
			end
		end
	end

	// frame geometry, fixed for the whole frame
	always_ff @(posedge clk) begin
		if (start_ok) begin
			base_out <= base_addr;
			width_q  <= frame_width;
			height_q <= frame_height;
		end
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && !req_ready |=> req_valid && $stable(req))
		else $error("read request changed before transfer");

	// memory must only answer a request this reader issued
	a_beat_in_read: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid |-> state == READ)
		else $error("beat outside READ state");

endmodule

//--- frame_memory.sv
// frame memory: pixel RAM with a load port and a single-burst read port
`timescale 1ns/1ps
`include "noise_est_macros.svh"

module frame_memory (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     wr_en,
	input  logic [`NE_ADDR_W-1:0]    wr_addr,
	input  logic [`NE_PIX_W-1:0]     wr_data,
	input  noise_est_pkg::rd_req_t   req,
	input  logic                     req_valid,
	output logic                     req_ready,
	output noise_est_pkg::rd_beat_t  beat,
	output logic                     beat_valid
);
	import noise_est_pkg::*;

	logic [`NE_PIX_W-1:0] mem [0:(1 << `NE_ADDR_W)-1];

	beat_cnt_t             remaining;  // beats still to send after the current one
	logic [`NE_ADDR_W-1:0] rd_addr;
	logic [`NE_ADDR_W-1:0] rd_sel;
	logic [`NE_PIX_W-1:0]  beat_pix;
	logic                  beat_last;
	logic                  fire;

	assign req_ready = (remaining == '0);  // free once the last beat is on the bus
	assign fire      = req_valid && req_ready;
	assign rd_sel    = fire ? req.addr : rd_addr;

	// load port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// burst sequencing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			remaining  <= '0;
			beat_valid <= 1'b0;
			beat_last  <= 1'b0;
		end else if (fire) begin
			remaining  <= req.len - 1'b1;
			beat_valid <= 1'b1;
			beat_last  <= (req.len == beat_cnt_t'(1));
		end else if (remaining != '0) begin
			remaining  <= remaining - 1'b1;
			beat_valid <= 1'b1;
			beat_last  <= (remaining == beat_cnt_t'(1));
		end else begin
			beat_valid <= 1'b0;
			beat_last  <= 1'b0;
		end
	end

	// registered read, first pixel one cycle after the request
	always_ff @(posedge clk) begin
		if (fire || remaining != '0) begin
			beat_pix <= mem[rd_sel];
			rd_addr  <= rd_sel + 1'b1;
		end
	end

	assign beat.pix  = beat_pix;
	assign beat.last = beat_last;

	// a zero-length burst would never raise last and stall the reader
	a_no_empty_burst: assert property (@(posedge clk) disable iff (!rst_n)
		fire |-> req.len != '0)
		else $error("zero-length burst request");

endmodule

//--- noise_est_pkg.sv
// noise estimator types: burst request, pixel beat, frame result and reader states
`include "noise_est_macros.svh"

package noise_est_pkg;

	// burst length field, wide enough to hold a full block row
	typedef logic [$clog2(`NE_BLOCK_SIZE):0] beat_cnt_t;

	// block count of the largest frame, (64/8)^2 = 64 needs 7 bits
	typedef logic [$clog2((`NE_MAX_DIM / `NE_BLOCK_SIZE) ** 2):0] blk_count_t;

	typedef struct packed {
		logic [`NE_ADDR_W-1:0] addr;  // first pixel of the burst
		beat_cnt_t             len;   // number of beats
	} rd_req_t;

	typedef struct packed {
		logic [`NE_PIX_W-1:0] pix;
		logic                 last;   // final beat of the burst
	} rd_beat_t;

	// handed to the wiener stage
	typedef struct packed {
		logic [`NE_ADDR_W-1:0]   base;
		logic [`NE_METRIC_W-1:0] metric;  // smallest block metric of the frame
		blk_count_t              blocks;
	} noise_result_t;

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		READ,
		FRAME_DONE
	} reader_state_t;

endpackage

//--- noise_est_macros.svh
// noise estimator sizing: block edge, pixel, address, dimension and metric widths
`ifndef NOISE_EST_MACROS_SVH
`define NOISE_EST_MACROS_SVH

// block edge in pixels, also the burst length
`define NE_BLOCK_SIZE 8

`define NE_PIX_W      8   // luma sample width
`define NE_ADDR_W     12  // 4096-pixel frame memory
`define NE_DIM_W      8   // frame width / height field

// 64*sum(x^2) - sum(x)^2 stays below 2^28 for 8-bit pixels
`define NE_METRIC_W   32

// largest supported frame edge
`define NE_MAX_DIM    64

`endif
